/* hdl/dist_config.svh */
`ifndef DIST_CONFIG_SVH
`define DIST_CONFIG_SVH

// lanes per side, same count on the input and output of both halves
`define DIST_LANES 4

// elements per group
`define DIST_GROUP 4

// element width in bits
`define DIST_DATA_W 8

// iteration and reads-per-iteration counter widths
`define DIST_ITER_W 16
`define DIST_READ_W 16

// input FIFO depth, avail logic assumes 2
`define DIST_FIFO_SLOTS 2

`endif

/* hdl/dist_pkg.sv */
`include "dist_config.svh"

package dist_pkg;

  typedef logic [`DIST_DATA_W-1:0] elem_t;                        // one element
  typedef logic [`DIST_GROUP*`DIST_DATA_W-1:0] group_t;           // one lane's group
  typedef logic [`DIST_LANES*`DIST_DATA_W-1:0] weight_t;          // one weight per output lane
  typedef group_t [`DIST_LANES-1:0] lanes_t;                      // all groups of one side
  typedef logic [`DIST_LANES-1:0] lane_mask_t;                    // one bit per lane

  typedef logic [`DIST_ITER_W-1:0] iter_cnt_t;
  typedef logic [`DIST_READ_W-1:0] read_cnt_t;

  // bcast on the input side, sum on the output side
  typedef enum logic {
    mode_bcast_sum = 1'b0,
    mode_direct    = 1'b1
  } dist_mode_t;

  // configure bus, sampled on the strobe
  typedef struct packed {
    dist_mode_t mode;
    iter_cnt_t  num_iters;   // iterations per run
    read_cnt_t  num_reads;   // reads per iteration
  } dist_cfg_t;

endpackage

/* hdl/dist_fifo.sv */
`timescale 1ns/1ps

`include "dist_config.svh"

// first-word-fall-through FIFO with the front word always on data_read
module dist_fifo (
  input  logic             clk,
  input  logic             rst,
  input  dist_pkg::group_t data_write,
  input  logic             write,
  input  logic             next_read,
  output dist_pkg::group_t data_read,
  output logic             empty,
  output logic             avail
);

  localparam int SLOTS = `DIST_FIFO_SLOTS;
  localparam int PTR_W = $clog2(SLOTS);
  localparam int CNT_W = $clog2(SLOTS + 1);

  dist_pkg::group_t mem [SLOTS];   // storage

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;         // words held
  logic             full;
  logic             almost_full;
  logic             push;
  logic             pop;

  assign full        = (count == CNT_W'(SLOTS));
  assign almost_full = (count == CNT_W'(SLOTS - 1));
  assign empty       = (count == '0);
  assign avail       = ~full & ~almost_full;   // only while empty at depth 2
  assign push        = write & ~full;
  assign pop         = next_read & ~empty;      // ignore pops on empty
  assign data_read   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= data_write;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(SLOTS - 1)) ? '0 : rd_ptr + 1'b1;
      // simultaneous push and pop keeps the count
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

endmodule

/* hdl/dist_in.sv */
`timescale 1ns/1ps

`include "dist_config.svh"

// activation and weight distributor
// runs num_iters iterations of num_reads reads, weights only on the first read
module dist_in (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   configure,
  input  dist_pkg::dist_cfg_t    cfg,
  input  dist_pkg::dist_mode_t   mode,              // registered in top
  input  dist_pkg::lanes_t       act_data,
  input  dist_pkg::lane_mask_t   act_valid,
  output dist_pkg::lane_mask_t   act_avail,
  input  dist_pkg::weight_t      weight_data,
  input  logic                   weight_valid,
  output logic                   weight_avail,
  output dist_pkg::lanes_t       out_data,
  output dist_pkg::lane_mask_t   out_valid,
  input  dist_pkg::lane_mask_t   out_avail,
  output dist_pkg::weight_t      out_weight,
  output dist_pkg::lane_mask_t   out_weight_valid,
  input  dist_pkg::lane_mask_t   out_weight_avail
);

  dist_pkg::lanes_t     act_front;     // FIFO heads
  dist_pkg::lane_mask_t act_empty;
  dist_pkg::lane_mask_t act_pop;
  dist_pkg::group_t     weight_front;
  logic                 weight_empty;
  logic                 weight_pop;

  dist_pkg::iter_cnt_t  iter_cnt;      // iterations left, down counter
  dist_pkg::read_cnt_t  read_cnt;      // reads left in this iteration
  dist_pkg::read_cnt_t  read_copy;     // reload value for read_cnt
  logic                 enabled;

  logic                 first_read;
  logic                 act_ready;
  logic                 weight_ready;
  logic                 fire;

  assign first_read = enabled & (read_cnt == read_copy);

  // broadcast needs lane 0 only, direct needs every lane
  assign act_ready = (mode == dist_pkg::mode_direct) ? ~(|act_empty) : ~act_empty[0];

  // weights matter on the first read only
  assign weight_ready = ~first_read | (~weight_empty & (&out_weight_avail));

  // no read in the configure cycle
  assign fire = enabled & ~configure & act_ready & (&out_avail) & weight_ready;

  assign weight_pop = fire & first_read;

  for (genvar i = 0; i < `DIST_LANES; i++) begin : g_lane
    // lanes 1 and up stay untouched in broadcast
    assign act_pop[i] = fire & ((mode == dist_pkg::mode_direct) || (i == 0));
    assign out_data[i] = (mode == dist_pkg::mode_direct) ? act_front[i] : act_front[0];

    dist_fifo u_act_fifo (
      .clk        (clk),
      .rst        (rst),
      .data_write (act_data[i]),
      .write      (act_valid[i]),
      .next_read  (act_pop[i]),
      .data_read  (act_front[i]),
      .empty      (act_empty[i]),
      .avail      (act_avail[i])
    );
  end

  // weight word shares the group width
  dist_fifo u_weight_fifo (
    .clk        (clk),
    .rst        (rst),
    .data_write (weight_data),
    .write      (weight_valid),
    .next_read  (weight_pop),
    .data_read  (weight_front),
    .empty      (weight_empty),
    .avail      (weight_avail)
  );

  assign out_valid        = {`DIST_LANES{fire}};
  assign out_weight       = weight_front;
  assign out_weight_valid = {`DIST_LANES{weight_pop}};

  always_ff @(posedge clk) begin
    if (!rst) begin
      iter_cnt  <= '0;
      read_cnt  <= '0;
      read_copy <= '0;
      enabled   <= 1'b0;
    end else if (configure) begin
      iter_cnt  <= cfg.num_iters;
      read_cnt  <= cfg.num_reads;
      read_copy <= cfg.num_reads;
      enabled   <= (|cfg.num_iters) & (|cfg.num_reads);   // zero counts keep it idle
    end else if (fire) begin
      if (read_cnt == dist_pkg::read_cnt_t'(1)) begin
        if (iter_cnt == dist_pkg::iter_cnt_t'(1)) begin
          enabled <= 1'b0;   // last read of last iteration
        end else begin
          iter_cnt <= iter_cnt - 1'b1;
          read_cnt <= read_copy;   // next iteration
        end
      end else begin
        read_cnt <= read_cnt - 1'b1;
      end
    end
  end

endmodule

/* hdl/dist_out.sv */
`timescale 1ns/1ps

`include "dist_config.svh"

// output distributor
// sum mode adds all lanes onto output 0, direct mode forwards lane i to output i
module dist_out (
  input  logic                 clk,
  input  logic                 rst,
  input  dist_pkg::dist_mode_t mode,
  input  dist_pkg::lanes_t     sum_in_data,
  input  dist_pkg::lane_mask_t sum_in_valid,
  output dist_pkg::lane_mask_t sum_in_avail,
  output dist_pkg::lanes_t     sum_out_data,
  output dist_pkg::lane_mask_t sum_out_valid,
  input  dist_pkg::lane_mask_t sum_out_avail
);

  localparam int W = `DIST_DATA_W;

  dist_pkg::lanes_t     in_front;    // FIFO heads
  dist_pkg::lane_mask_t in_empty;
  dist_pkg::lanes_t     partial;     // running sum, partial[i] covers lanes 0..i
  logic                 fire;

  // every lane present and every output free
  assign fire = ~(|in_empty) & (&sum_out_avail);

  assign partial[0] = in_front[0];

  // adder chain, element by element, wraps at 2^W
  for (genvar i = 1; i < `DIST_LANES; i++) begin : g_chain
    for (genvar j = 0; j < `DIST_GROUP; j++) begin : g_elem
      dist_pkg::elem_t a;
      dist_pkg::elem_t b;
      assign a = partial[i-1][j*W +: W];
      assign b = in_front[i][j*W +: W];
      assign partial[i][j*W +: W] = a + b;
    end
  end

  for (genvar i = 0; i < `DIST_LANES; i++) begin : g_lane
    dist_fifo u_in_fifo (
      .clk        (clk),
      .rst        (rst),
      .data_write (sum_in_data[i]),
      .write      (sum_in_valid[i]),
      .next_read  (fire),            // all lanes pop together
      .data_read  (in_front[i]),
      .empty      (in_empty[i]),
      .avail      (sum_in_avail[i])
    );

    // sum shows on every group, valid says which one counts
    assign sum_out_data[i] = (mode == dist_pkg::mode_direct) ? in_front[i]
                                                             : partial[`DIST_LANES-1];
    if (i == 0) begin : g_valid0
      assign sum_out_valid[i] = fire;
    end else begin : g_validn
      assign sum_out_valid[i] = fire & (mode == dist_pkg::mode_direct);
    end
  end

endmodule

/* hdl/dist_top.sv */
`timescale 1ns/1ps

// distribution stage top, one mode register shared by both halves
module dist_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 configure,
  input  dist_pkg::dist_cfg_t  cfg,
  input  dist_pkg::lanes_t     act_data,
  input  dist_pkg::lane_mask_t act_valid,
  output dist_pkg::lane_mask_t act_avail,
  input  dist_pkg::weight_t    weight_data,
  input  logic                 weight_valid,
  output logic                 weight_avail,
  output dist_pkg::lanes_t     out_data,
  output dist_pkg::lane_mask_t out_valid,
  input  dist_pkg::lane_mask_t out_avail,
  output dist_pkg::weight_t    out_weight,
  output dist_pkg::lane_mask_t out_weight_valid,
  input  dist_pkg::lane_mask_t out_weight_avail,
  input  dist_pkg::lanes_t     sum_in_data,
  input  dist_pkg::lane_mask_t sum_in_valid,
  output dist_pkg::lane_mask_t sum_in_avail,
  output dist_pkg::lanes_t     sum_out_data,
  output dist_pkg::lane_mask_t sum_out_valid,
  input  dist_pkg::lane_mask_t sum_out_avail
);

  dist_pkg::dist_mode_t mode;   // latched on the strobe

  always_ff @(posedge clk) begin
    if (!rst) mode <= dist_pkg::mode_bcast_sum;
    else if (configure) mode <= cfg.mode;
  end

  dist_in u_in (
    .clk              (clk),
    .rst              (rst),
    .configure        (configure),
    .cfg              (cfg),          // raw counts, loaded on the strobe
    .mode             (mode),
    .act_data         (act_data),
    .act_valid        (act_valid),
    .act_avail        (act_avail),
    .weight_data      (weight_data),
    .weight_valid     (weight_valid),
    .weight_avail     (weight_avail),
    .out_data         (out_data),
    .out_valid        (out_valid),
    .out_avail        (out_avail),
    .out_weight       (out_weight),
    .out_weight_valid (out_weight_valid),
    .out_weight_avail (out_weight_avail)
  );

  dist_out u_out (
    .clk           (clk),
    .rst           (rst),
    .mode          (mode),
    .sum_in_data   (sum_in_data),
    .sum_in_valid  (sum_in_valid),
    .sum_in_avail  (sum_in_avail),
    .sum_out_data  (sum_out_data),
    .sum_out_valid (sum_out_valid),
    .sum_out_avail (sum_out_avail)
  );

endmodule

/* sim/dist_ref.svh */
`ifndef DIST_REF_SVH
`define DIST_REF_SVH

// expected out_data of dist_in, lane 0 on every output in broadcast
function automatic dist_pkg::lanes_t route_expect(dist_pkg::dist_mode_t m,
                                                  dist_pkg::lanes_t a);
  dist_pkg::lanes_t r;
  for (int i = 0; i < `DIST_LANES; i++) begin
    r[i] = (m == dist_pkg::mode_direct) ? a[i] : a[0];
  end
  return r;
endfunction

// element by element over all lanes, wraps at the element width
function automatic dist_pkg::group_t lane_sum(dist_pkg::lanes_t a);
  dist_pkg::group_t s;
  dist_pkg::elem_t  e;
  for (int j = 0; j < `DIST_GROUP; j++) begin
    e = '0;
    for (int i = 0; i < `DIST_LANES; i++)
      e = e + a[i][j*`DIST_DATA_W +: `DIST_DATA_W];
    s[j*`DIST_DATA_W +: `DIST_DATA_W] = e;
  end
  return s;
endfunction

// expected sum_out_data, only lanes with valid set get compared
function automatic dist_pkg::lanes_t sum_expect(dist_pkg::dist_mode_t m,
                                                dist_pkg::lanes_t a);
  dist_pkg::lanes_t r;
  for (int i = 0; i < `DIST_LANES; i++) begin
    r[i] = (m == dist_pkg::mode_direct) ? a[i] : lane_sum(a);
  end
  return r;
endfunction

`endif

/* sim/dist_tb.sv */
`timescale 1ns/1ps

`include "dist_config.svh"

module dist_tb;

  localparam int stim_cycles = 1000;   // rough bound on all tests together
  localparam int max_cycles  = 4 * stim_cycles;

  logic                 clk;
  logic                 rst;
  logic                 configure;
  dist_pkg::dist_cfg_t  cfg;
  dist_pkg::lanes_t     act_data, out_data, sum_in_data, sum_out_data;
  dist_pkg::lane_mask_t act_valid, act_avail, out_valid, out_avail;
  dist_pkg::lane_mask_t out_weight_valid, out_weight_avail;
  dist_pkg::lane_mask_t sum_in_valid, sum_in_avail, sum_out_valid, sum_out_avail;
  dist_pkg::weight_t    weight_data, out_weight;
  logic                 weight_valid, weight_avail;

  integer               seed = 32'habfaeff4;
  int                   cycles, errors, tests, out_fires, weight_fires;
  logic                 bp_stop;
  dist_pkg::dist_mode_t cur_mode;      // mode the DUT runs in
  dist_pkg::lanes_t     last_act;      // last activation word sent
  dist_pkg::lanes_t     act_exp[$];    // expected out_data per fire
  dist_pkg::weight_t    weight_exp[$];
  dist_pkg::lanes_t     sum_exp[$];

  `include "dist_ref.svh"

  dist_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit
  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, expected words never came out", cycles);
    $display("TEST FAILED");
    $finish;
  end

  task automatic log_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // compare every output strobe at negedge
  always @(negedge clk) begin
    dist_pkg::lanes_t     exp;
    dist_pkg::weight_t    w;
    dist_pkg::lane_mask_t vmask;
    if (|out_valid) begin
      out_fires++;
      assert (&out_avail) else log_error("out_valid raised while an out_avail bit is low");
      assert (out_valid == '1)
        else log_error($sformatf("** Error out_valid: expected %h, got %h",
                                 dist_pkg::lane_mask_t'('1), out_valid));
      assert (act_exp.size() != 0) else log_error("out_valid with no word expected");
      if (act_exp.size() != 0) begin
        exp = act_exp.pop_front();
        assert (out_data == exp)
          else log_error($sformatf("** Error out_data: expected %h, got %h", exp, out_data));
      end
    end
    if (|out_weight_valid) begin
      weight_fires++;
      assert (out_weight_valid == '1 && out_valid == '1)
        else log_error("out_weight_valid without a full out_valid");
      assert (weight_exp.size() != 0) else log_error("out_weight_valid with no weight expected");
      if (weight_exp.size() != 0) begin
        w = weight_exp.pop_front();
        assert (out_weight == w)
          else log_error($sformatf("** Error out_weight: expected %h, got %h", w, out_weight));
      end
    end
    if (|sum_out_valid) begin
      vmask = (cur_mode == dist_pkg::mode_direct) ? '1 : dist_pkg::lane_mask_t'(1);
      assert (sum_out_valid == vmask)
        else log_error($sformatf("** Error sum_out_valid: expected %h, got %h",
                                 vmask, sum_out_valid));
      assert (sum_exp.size() != 0) else log_error("sum_out_valid with no group expected");
      if (sum_exp.size() != 0) begin
        exp = sum_exp.pop_front();
        for (int i = 0; i < `DIST_LANES; i++) begin
          assert (!vmask[i] || sum_out_data[i] == exp[i])
            else log_error($sformatf("** Error sum_out_data[%0d]: expected %h, got %h",
                                     i, exp[i], sum_out_data[i]));
        end
      end
    end
  end

  task automatic configure_dut(input dist_pkg::dist_mode_t m, input int iters,
                               input int reads);
    @(posedge clk);
    configure     <= 1'b1;
    cfg.mode      <= m;
    cfg.num_iters <= dist_pkg::iter_cnt_t'(iters);
    cfg.num_reads <= dist_pkg::read_cnt_t'(reads);
    @(posedge clk);
    configure <= 1'b0;
    cur_mode = m;   // mode register loaded at this edge
  endtask

  // one word per pulse into an empty FIFO
  task automatic send_acts(input dist_pkg::dist_mode_t m, input int n, input bit track);
    dist_pkg::lane_mask_t mask;
    mask = (m == dist_pkg::mode_direct) ? '1 : dist_pkg::lane_mask_t'(1);
    for (int k = 0; k < n; k++) begin
      for (int i = 0; i < `DIST_LANES; i++)
        last_act[i] = $random(seed);
      if (track) act_exp.push_back(route_expect(m, last_act));
      @(negedge clk);
      while ((act_avail & mask) != mask) @(negedge clk);
      @(posedge clk);
      act_data  <= last_act;
      act_valid <= mask;
      @(posedge clk);
      act_valid <= '0;
    end
  endtask

  task automatic send_weights(input int n);
    dist_pkg::weight_t w;
    for (int k = 0; k < n; k++) begin
      w = $random(seed);
      weight_exp.push_back(w);
      @(negedge clk);
      while (!weight_avail) @(negedge clk);
      @(posedge clk);
      weight_data  <= w;
      weight_valid <= 1'b1;
      @(posedge clk);
      weight_valid <= 1'b0;
    end
  endtask

  task automatic send_sums(input dist_pkg::dist_mode_t m, input int n);
    dist_pkg::lanes_t g;
    for (int k = 0; k < n; k++) begin
      for (int i = 0; i < `DIST_LANES; i++)
        g[i] = $random(seed);
      sum_exp.push_back(sum_expect(m, g));
      @(negedge clk);
      while (sum_in_avail != '1) @(negedge clk);
      @(posedge clk);
      sum_in_data  <= g;
      sum_in_valid <= '1;
      @(posedge clk);
      sum_in_valid <= '0;
    end
  endtask

  // one random out_avail bit low for random stretches
  task automatic back_pressure;
    int lane;
    int len;
    while (!bp_stop) begin
      lane = $unsigned($random(seed)) % `DIST_LANES;
      len  = 1 + $unsigned($random(seed)) % 6;
      @(posedge clk);
      out_avail <= ~(dist_pkg::lane_mask_t'(1) << lane);
      repeat (len) @(posedge clk);
      out_avail <= '1;
      repeat (len) @(posedge clk);
    end
  endtask

  task automatic wait_drain;
    @(negedge clk);
    while (act_exp.size() + weight_exp.size() + sum_exp.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);   // room for stray strobes
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("%-14s %s", name, (errors == err0) ? "ok" : "errors seen");
  endtask

  initial begin
    int err0;
    rst              <= 1'b0;
    configure        <= 1'b0;
    cfg              <= '0;
    act_data         <= '0;
    act_valid        <= '0;
    weight_data      <= '0;
    weight_valid     <= 1'b0;
    out_avail        <= '1;
    out_weight_avail <= '1;
    sum_in_data      <= '0;
    sum_in_valid     <= '0;
    sum_out_avail    <= '1;
    bp_stop  = 1'b0;
    cur_mode = dist_pkg::mode_bcast_sum;
    repeat (4) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    assert (act_avail == '1 && weight_avail && sum_in_avail == '1 && out_valid == '0)
      else log_error("avail or valid outputs wrong after reset");

    // 3 iterations of 4 reads with a weight on each first read
    err0 = errors;
    configure_dut(dist_pkg::mode_bcast_sum, 3, 4);
    fork
      send_acts(dist_pkg::mode_bcast_sum, 12, 1'b1);
      send_weights(3);
    join
    wait_drain();
    assert (out_fires == 12) else log_error("broadcast run did not give 12 out_valid pulses");
    assert (weight_fires == 3) else log_error("broadcast run did not give 3 weight pulses");
    end_test("broadcast", err0);

    // stray word waits for the next configure
    err0 = errors;
    send_acts(dist_pkg::mode_bcast_sum, 1, 1'b0);
    repeat (20) @(negedge clk);
    assert (out_fires == 12) else log_error("out_valid after the run had finished");
    act_exp.push_back(route_expect(dist_pkg::mode_bcast_sum, last_act));
    configure_dut(dist_pkg::mode_bcast_sum, 1, 1);
    send_weights(1);
    wait_drain();
    end_test("self-disable", err0);

    err0 = errors;
    configure_dut(dist_pkg::mode_direct, 2, 3);
    fork
      send_acts(dist_pkg::mode_direct, 6, 1'b1);
      send_weights(2);
    join
    wait_drain();
    end_test("direct", err0);

    err0 = errors;
    configure_dut(dist_pkg::mode_direct, 2, 5);
    fork
      back_pressure();
      begin
        fork
          send_acts(dist_pkg::mode_direct, 10, 1'b1);
          send_weights(2);
        join
        wait_drain();
        bp_stop = 1'b1;
      end
    join
    end_test("back-pressure", err0);

    // zero counts keep dist_in idle while the mode changes
    err0 = errors;
    configure_dut(dist_pkg::mode_bcast_sum, 0, 0);
    send_sums(dist_pkg::mode_bcast_sum, 6);
    wait_drain();
    end_test("sum", err0);

    err0 = errors;
    configure_dut(dist_pkg::mode_direct, 0, 0);
    send_sums(dist_pkg::mode_direct, 6);
    wait_drain();
    end_test("sum direct", err0);

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* dist.f */
+incdir+hdl
+incdir+sim
hdl/dist_pkg.sv
hdl/dist_fifo.sv
hdl/dist_in.sv
hdl/dist_out.sv
hdl/dist_top.sv
sim/dist_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = dist_tb
FILELIST  = dist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
